// File: include/csr_config_settings.svh
`ifndef CSR_CONFIG_SETTINGS_SVH
`define CSR_CONFIG_SETTINGS_SVH

// Response word fields
`define CFG_DATA_W       32
`define CFG_OFFSET_W     16

// Configuration layout
`define CFG_SEQ_WIDTH    16
`define CFG_GRAN_W       4
`define CFG_PTR_W        (2 * `CFG_DATA_W)

// FIFO sizing, shared by the response and output queues
`define CFG_FIFO_DEPTH   16
`define CFG_PROG_THRESH  8

// Relative slot of this engine, selects its offset window
`define CFG_ENGINE_SLOT  1
`define CFG_WINDOW_START (`CFG_ENGINE_SLOT * `CFG_SEQ_WIDTH)

`endif

// File: rtl/csr_config_pkg.sv
`default_nettype none

`include "csr_config_settings.svh"

package csr_config_pkg;

    // Class of a memory response word
    typedef enum logic [1:0] {
        STRUCT_INVALID      = 2'd0,
        STRUCT_CU_SETUP     = 2'd1,
        STRUCT_ENGINE_SETUP = 2'd2,
        STRUCT_DATA         = 2'd3
    } buffer_class_e;

    // Field decoded at each position of a configuration sequence
    typedef enum logic [3:0] {
        WORD_MODES       = 4'd0,
        WORD_INDEX_START = 4'd1,
        WORD_INDEX_END   = 4'd2,
        WORD_STRIDE      = 4'd3,
        WORD_GRANULARITY = 4'd4,
        WORD_CMD         = 4'd5,
        WORD_ROUTE       = 4'd6,
        WORD_PTR_LO      = 4'd7,
        WORD_PTR_HI      = 4'd8,
        WORD_ARRAY_SIZE  = 4'd9,
        WORD_RESERVED    = 4'd10
    } cfg_word_e;

    typedef struct packed {
        logic                     valid;
        buffer_class_e            buffer_class;
        logic [`CFG_OFFSET_W-1:0] offset;
        logic [`CFG_DATA_W-1:0]   data;
    } response_word_t;

    // Stored in the response FIFO
    typedef struct packed {
        buffer_class_e            buffer_class;
        logic [`CFG_OFFSET_W-1:0] offset;
        logic [`CFG_DATA_W-1:0]   data;
    } response_payload_t;

    typedef struct packed {
        logic                   increment;
        logic                   decrement;
        logic                   mode_sequence;
        logic                   mode_buffer;
        logic                   mode_break;
        logic                   mode_filter;
        logic [`CFG_DATA_W-1:0] index_start;
        logic [`CFG_DATA_W-1:0] index_end;
        logic [`CFG_DATA_W-1:0] stride;
        logic [`CFG_GRAN_W-1:0] granularity;
        logic                   direction;
        logic [`CFG_PTR_W-1:0]  array_pointer;
        logic [`CFG_DATA_W-1:0] array_size;
    } csr_index_config_t;

    typedef struct packed {
        logic              valid;
        csr_index_config_t payload;
    } config_out_t;

endpackage : csr_config_pkg

`default_nettype wire

// File: rtl/setup_word_filter.sv
`default_nettype none

`include "csr_config_settings.svh"

module setup_word_filter
    import csr_config_pkg::*;
(
    input  logic              ap_clk,
    input  logic              areset_csr_index_generator,
    input  response_word_t    response_in,
    output logic              push,
    output response_payload_t push_payload
);

    localparam int OFFSET_W   = `CFG_OFFSET_W;
    localparam int WIN_LO_INT = `CFG_WINDOW_START;
    localparam int WIN_HI_INT = `CFG_WINDOW_START + `CFG_SEQ_WIDTH;

    localparam logic [OFFSET_W-1:0] WIN_LO = WIN_LO_INT[OFFSET_W-1:0];
    localparam logic [OFFSET_W-1:0] WIN_HI = WIN_HI_INT[OFFSET_W-1:0];

    response_word_t in_q;
    logic           class_ok;
    logic           window_ok;

    // --------------------------------------------------
    // Input register
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            in_q.valid <= 1'b0;
        end else begin
            in_q.valid <= response_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        in_q.buffer_class <= response_in.buffer_class;
        in_q.offset       <= response_in.offset;
        in_q.data         <= response_in.data;
    end

    // --------------------------------------------------
    // Filter decision
    // --------------------------------------------------
    // Only setup words inside this engine's window are kept
    assign class_ok  = (in_q.buffer_class == STRUCT_CU_SETUP) ||
                       (in_q.buffer_class == STRUCT_ENGINE_SETUP);
    assign window_ok = (in_q.offset >= WIN_LO) && (in_q.offset < WIN_HI);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            push <= 1'b0;
        end else begin
            push <= in_q.valid & class_ok & window_ok;
        end
    end

    always_ff @(posedge ap_clk) begin
        push_payload.buffer_class <= in_q.buffer_class;
        push_payload.offset       <= in_q.offset;
        push_payload.data         <= in_q.data;
    end

endmodule : setup_word_filter

`default_nettype wire

// File: rtl/sync_fifo.sv
`default_nettype none

`include "csr_config_settings.svh"

module sync_fifo #(
    parameter int DATA_W      = `CFG_DATA_W,
    parameter int DEPTH       = `CFG_FIFO_DEPTH,
    parameter int PROG_THRESH = `CFG_PROG_THRESH
) (
    input  logic              ap_clk,
    input  logic              areset_csr_index_generator,
    input  logic              push,
    input  logic [DATA_W-1:0] push_data,
    input  logic              pop,
    output logic [DATA_W-1:0] pop_data,
    output logic              out_valid,
    output logic              empty,
    output logic              full,
    output logic              prog_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_PTR  = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(DEPTH);
    localparam logic [CNT_W-1:0] PROG_CNT  = CNT_W'(PROG_THRESH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push_ok;
    logic              pop_ok;

    assign empty     = (count == '0);
    assign full      = (count == DEPTH_CNT);
    assign prog_full = (count >= PROG_CNT);

    assign push_ok = push & ~full;
    assign pop_ok  = pop & ~empty;

    // --------------------------------------------------
    // Pointers and fill level
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop_ok;
            if (push_ok) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
        if (pop_ok) begin
            pop_data <= mem[rd_ptr];
        end
    end

    a_no_push_full : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator) !(push && full))
        else $error("push while FIFO full");

    a_no_pop_empty : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator) !(pop && empty))
        else $error("pop while FIFO empty");

endmodule : sync_fifo

`default_nettype wire

// File: rtl/csr_config_assembler.sv
`default_nettype none

`include "csr_config_settings.svh"

module csr_config_assembler
    import csr_config_pkg::*;
(
    input  logic              ap_clk,
    input  logic              areset_csr_index_generator,
    input  response_payload_t word_in,
    input  logic              word_valid,
    input  logic              word_empty,
    input  logic              out_prog_full,
    output logic              word_pop,
    output logic              cfg_push,
    output csr_index_config_t cfg_data
);

    localparam int SEQ_W         = `CFG_SEQ_WIDTH;
    localparam int OFFSET_W      = `CFG_OFFSET_W;
    localparam int DATA_W        = `CFG_DATA_W;
    localparam int WIN_START_INT = `CFG_WINDOW_START;

    localparam logic [OFFSET_W-1:0] WIN_START = WIN_START_INT[OFFSET_W-1:0];

    logic [SEQ_W-1:0]  seq_q;
    response_payload_t word_q;
    logic              word_q_valid;
    logic              done_q;
    csr_index_config_t cfg_q;
    cfg_word_e         position;

    // Hold off while emitting or while the output queue backs up
    assign word_pop = ~word_empty & ~out_prog_full & ~cfg_push;

    // --------------------------------------------------
    // One-hot sequencing
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            seq_q        <= '0;
            word_q_valid <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            word_q_valid <= word_valid;
            done_q       <= word_q_valid & seq_q[SEQ_W-1];
            if (word_valid) begin
                // First offset of the window restarts the sequence
                if (word_in.offset == WIN_START) begin
                    seq_q <= {{(SEQ_W-1){1'b0}}, 1'b1};
                end else begin
                    seq_q <= seq_q << 1;
                end
            end else if (seq_q[SEQ_W-1]) begin
                seq_q <= '0;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        word_q <= word_in;
    end

    // Field position of the set sequence bit
    // Reserved when no bit is set
    always_comb begin
        position = WORD_RESERVED;
        for (int i = 0; i < SEQ_W; i++) begin
            if (seq_q[i]) begin
                position = cfg_word_e'(4'(i));
            end
        end
    end

    // --------------------------------------------------
    // Field decode
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (word_q_valid) begin
            case (position)
                WORD_MODES: begin
                    cfg_q.increment     <= word_q.data[0];
                    cfg_q.decrement     <= word_q.data[1];
                    cfg_q.mode_sequence <= word_q.data[2];
                    cfg_q.mode_buffer   <= word_q.data[3];
                    cfg_q.mode_break    <= word_q.data[4];
                    cfg_q.mode_filter   <= word_q.data[5];
                end
                WORD_INDEX_START: cfg_q.index_start <= word_q.data;
                WORD_INDEX_END:   cfg_q.index_end   <= word_q.data;
                WORD_STRIDE:      cfg_q.stride      <= word_q.data;
                WORD_GRANULARITY: begin
                    cfg_q.granularity <= word_q.data[`CFG_GRAN_W-1:0];
                    cfg_q.direction   <= word_q.data[DATA_W-1];
                end
                // Command and routing words carry nothing kept here
                WORD_CMD, WORD_ROUTE: begin
                end
                WORD_PTR_LO: cfg_q.array_pointer[DATA_W-1:0]          <= word_q.data;
                WORD_PTR_HI: cfg_q.array_pointer[2*DATA_W-1:DATA_W]   <= word_q.data;
                WORD_ARRAY_SIZE: cfg_q.array_size <= word_q.data;
                default: begin
                end
            endcase
        end
    end

    // Completion marked one cycle after the last word is decoded
    assign cfg_push = done_q;
    assign cfg_data = cfg_q;

endmodule : csr_config_assembler

`default_nettype wire

// File: rtl/csr_index_config_top.sv
`default_nettype none

`include "csr_config_settings.svh"

module csr_index_config_top
    import csr_config_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_csr_index_generator,
    input  response_word_t response_in,
    input  logic           config_ready,
    output config_out_t    config_out,
    output logic           resp_full
);

    // Filter to response FIFO
    logic              resp_push;
    response_payload_t resp_push_data;

    // Response FIFO to assembler
    logic              resp_pop;
    response_payload_t resp_pop_data;
    logic              resp_valid;
    logic              resp_empty;

    // Assembler to output FIFO
    logic              cfg_push;
    csr_index_config_t cfg_push_data;
    logic              cfg_pop;
    csr_index_config_t cfg_pop_data;
    logic              cfg_valid;
    logic              cfg_empty;
    logic              cfg_prog_full;

    setup_word_filter i_filter (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response_in                (response_in),
        .push                       (resp_push),
        .push_payload               (resp_push_data)
    );

    sync_fifo #(
        .DATA_W      ($bits(response_payload_t)),
        .DEPTH       (`CFG_FIFO_DEPTH),
        .PROG_THRESH (`CFG_PROG_THRESH)
    ) i_resp_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .push                       (resp_push),
        .push_data                  (resp_push_data),
        .pop                        (resp_pop),
        .pop_data                   (resp_pop_data),
        .out_valid                  (resp_valid),
        .empty                      (resp_empty),
        .full                       (resp_full),
        .prog_full                  ()
    );

    csr_config_assembler i_assembler (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .word_in                    (resp_pop_data),
        .word_valid                 (resp_valid),
        .word_empty                 (resp_empty),
        .out_prog_full              (cfg_prog_full),
        .word_pop                   (resp_pop),
        .cfg_push                   (cfg_push),
        .cfg_data                   (cfg_push_data)
    );

    // Drained by the outside world while ready is held
    assign cfg_pop = config_ready & ~cfg_empty;

    sync_fifo #(
        .DATA_W      ($bits(csr_index_config_t)),
        .DEPTH       (`CFG_FIFO_DEPTH),
        .PROG_THRESH (`CFG_PROG_THRESH)
    ) i_cfg_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .push                       (cfg_push),
        .push_data                  (cfg_push_data),
        .pop                        (cfg_pop),
        .pop_data                   (cfg_pop_data),
        .out_valid                  (cfg_valid),
        .empty                      (cfg_empty),
        .full                       (),
        .prog_full                  (cfg_prog_full)
    );

    assign config_out.valid   = cfg_valid;
    assign config_out.payload = cfg_pop_data;

endmodule : csr_index_config_top

`default_nettype wire

// File: test/tb_csr_index_config.sv
`default_nettype none

`include "csr_config_settings.svh"

module tb_csr_index_config
    import csr_config_pkg::*;
();

    localparam int SEQ_W     = `CFG_SEQ_WIDTH;
    localparam int WIN_START = `CFG_WINDOW_START;
    // About 150 words over five tests, plus settle and hold time
    localparam int TEST_CYCLES = 1500;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    typedef logic [`CFG_DATA_W-1:0] word_set_t [SEQ_W];

    logic           ap_clk;
    logic           areset_csr_index_generator;
    response_word_t response_in;
    logic           config_ready;
    config_out_t    config_out;
    logic           resp_full;

    csr_index_config_t exp_q [$];
    csr_index_config_t exp_head;
    logic              exp_avail;
    logic              idle_check;
    logic [31:0]       rng;
    word_set_t         words;
    int                cycle_count;
    int                error_count;
    int                errors_before;
    int                pass_count;
    int                fail_count;

    csr_index_config_top i_dut (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response_in                (response_in),
        .config_ready               (config_ready),
        .config_out                 (config_out),
        .resp_full                  (resp_full)
    );

    initial ap_clk = 1'b0;
    always #10 ap_clk = ~ap_clk;

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Word at position i of the sequence feeds the field named for i
    function automatic csr_index_config_t expected_config(input word_set_t w);
        csr_index_config_t c;
        c = '0;
        c.increment     = w[0][0];
        c.decrement     = w[0][1];
        c.mode_sequence = w[0][2];
        c.mode_buffer   = w[0][3];
        c.mode_break    = w[0][4];
        c.mode_filter   = w[0][5];
        c.index_start   = w[1];
        c.index_end     = w[2];
        c.stride        = w[3];
        c.granularity   = w[4][3:0];
        c.direction     = w[4][31];
        c.array_pointer = {w[8], w[7]};
        c.array_size    = w[9];
        return c;
    endfunction

    // Head of the expected queue, refreshed between edges
    always @(negedge ap_clk) begin
        exp_avail = (exp_q.size() != 0);
        if (exp_q.size() != 0) begin
            exp_head = exp_q[0];
        end
    end

    always @(posedge ap_clk) begin
        if (config_out.valid && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_config_match : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        (config_out.valid && exp_avail) |-> (config_out.payload == exp_head))
        else begin
            error_count++;
            $display("CHECK FAILED config_out.payload: got %h expected %h",
                     $sampled(config_out.payload), $sampled(exp_head));
        end

    a_config_expected : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        config_out.valid |-> exp_avail)
        else begin
            error_count++;
            $display("configuration appeared on config_out when none was expected");
        end

    a_idle_no_output : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        idle_check |-> !config_out.valid)
        else begin
            error_count++;
            $display("CHECK FAILED config_out.valid: got %h expected %h",
                     $sampled(config_out.valid), 1'b0);
        end

    a_idle_not_full : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        idle_check |-> !resp_full)
        else begin
            error_count++;
            $display("CHECK FAILED resp_full: got %h expected %h",
                     $sampled(resp_full), 1'b0);
        end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic fill_words();
        for (int i = 0; i < SEQ_W; i++) begin
            rng = xorshift32(rng);
            words[i] = rng;
        end
    endtask

    task automatic send_word(input buffer_class_e cls, input int offset,
                             input logic [31:0] data);
        while (resp_full) begin
            @(posedge ap_clk);
            #2;
        end
        response_in.valid        = 1'b1;
        response_in.buffer_class = cls;
        response_in.offset       = 16'(offset);
        response_in.data         = data;
        @(posedge ap_clk);
        #2;
        response_in.valid = 1'b0;
    endtask

    // First count words of the set, with dropped words after each when noisy
    task automatic send_sequence(input int count, input bit noisy);
        buffer_class_e cls;
        for (int i = 0; i < count; i++) begin
            cls = i[0] ? STRUCT_ENGINE_SETUP : STRUCT_CU_SETUP;
            send_word(cls, WIN_START + i, words[i]);
            if (noisy) begin
                rng = xorshift32(rng);
                send_word(STRUCT_DATA, WIN_START + i, rng);
                send_word(STRUCT_CU_SETUP, WIN_START + SEQ_W + i, rng ^ 32'h5a5a_5a5a);
                send_word(STRUCT_ENGINE_SETUP, WIN_START - 1, ~rng);
            end
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge ap_clk);
        end
        // A few spare cycles so a stray output still gets caught
        repeat (4) @(posedge ap_clk);
        #2;
    endtask

    task automatic finish_test(input int num, input string name);
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %0d %s: passed", num, name);
        end else begin
            fail_count++;
            $display("test %0d %s: failed with %0d errors", num, name,
                     error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge ap_clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        areset_csr_index_generator = 1'b1;
        response_in   = '0;
        config_ready  = 1'b1;
        idle_check    = 1'b0;
        exp_avail     = 1'b0;
        exp_head      = '0;
        rng           = 32'heab1acb8;
        error_count   = 0;
        errors_before = 0;
        pass_count    = 0;
        fail_count    = 0;
        repeat (3) @(posedge ap_clk);
        #2;
        areset_csr_index_generator = 1'b0;

        idle_check = 1'b1;
        repeat (10) @(posedge ap_clk);
        #2;
        idle_check = 1'b0;
        finish_test(1, "idle after reset");

        fill_words();
        exp_q.push_back(expected_config(words));
        send_sequence(SEQ_W, 1'b0);
        wait_drained();
        finish_test(2, "single configuration");

        fill_words();
        exp_q.push_back(expected_config(words));
        send_sequence(SEQ_W, 1'b1);
        wait_drained();
        finish_test(3, "filtered class and offset");

        // Partial sequence, then restart at the first offset
        fill_words();
        send_sequence(7, 1'b0);
        fill_words();
        exp_q.push_back(expected_config(words));
        send_sequence(SEQ_W, 1'b0);
        wait_drained();
        finish_test(4, "restart mid sequence");

        config_ready = 1'b0;
        idle_check   = 1'b1;
        for (int n = 0; n < 3; n++) begin
            fill_words();
            exp_q.push_back(expected_config(words));
            send_sequence(SEQ_W, 1'b0);
        end
        repeat (20) @(posedge ap_clk);
        #2;
        idle_check   = 1'b0;
        config_ready = 1'b1;
        wait_drained();
        finish_test(5, "held output queue");

        $display("tests passed %0d failed %0d, check errors %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_csr_index_config

`default_nettype wire

// File: csr_index_config_top.f
+incdir+include
rtl/csr_config_pkg.sv
rtl/setup_word_filter.sv
rtl/sync_fifo.sv
rtl/csr_config_assembler.sv
rtl/csr_index_config_top.sv
test/tb_csr_index_config.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f csr_index_config_top.f \
    --top-module tb_csr_index_config -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    && grep -q "^RESULT: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
